// ==== src/exec_pkg.sv ====
package exec_pkg;

    // datapath and tag widths
    localparam int xlen = 32;
    localparam int rob_idx_w = 6;
    localparam int preg_w = 6;

    // multiplier pipeline depth, issue to result slot
    localparam int mul_stages = 4;

    // integer alu operations, register and immediate forms share these
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_t;

    // conditional branches plus the two jumps
    typedef enum logic [2:0] {
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_jal,
        br_jalr
    } br_op_t;

    // m extension multiplies
    typedef enum logic [1:0] {
        mul_mul,
        mul_mulh,
        mul_mulhsu,
        mul_mulhu
    } mul_op_t;

    // cdb arbitration order
    typedef enum logic [1:0] {
        sel_alu,
        sel_br,
        sel_mul
    } unit_sel_t;

endpackage

// ==== src/fu_alu.sv ====
`timescale 1ns/100ps

module fu_alu (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            alu_valid,
    input  exec_pkg::alu_op_t               alu_op,
    input  logic [exec_pkg::xlen-1:0]       alu_a,
    input  logic [exec_pkg::xlen-1:0]       alu_b,
    input  logic [exec_pkg::rob_idx_w-1:0]  alu_rob_idx,
    input  logic [exec_pkg::preg_w-1:0]     alu_pd,
    output logic                            alu_ready,
    output logic                            res_valid,
    output logic [exec_pkg::rob_idx_w-1:0]  res_rob_idx,
    output logic [exec_pkg::preg_w-1:0]     res_pd,
    output logic [exec_pkg::xlen-1:0]       res_value,
    input  logic                            res_take
);
    import exec_pkg::*;

    logic [xlen-1:0] result;
    logic [4:0]      shamt;

    assign shamt = alu_b[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  result = alu_a + alu_b;
            alu_sub:  result = alu_a - alu_b;
            alu_and:  result = alu_a & alu_b;
            alu_or:   result = alu_a | alu_b;
            alu_xor:  result = alu_a ^ alu_b;
            alu_sll:  result = alu_a << shamt;
            alu_srl:  result = alu_a >> shamt;
            alu_sra:  result = $unsigned($signed(alu_a) >>> shamt);
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, alu_a < alu_b};
            default:  result = '0;
        endcase
    end

    // slot frees up in the same cycle it is taken
    assign alu_ready = !res_valid || res_take;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (alu_valid && alu_ready) begin
            res_valid <= 1'b1;
        end else if (res_take) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid && alu_ready) begin
            res_rob_idx <= alu_rob_idx;
            res_pd      <= alu_pd;
            res_value   <= result;
        end
    end

endmodule

// ==== src/fu_branch.sv ====
`timescale 1ns/100ps

module fu_branch (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            br_valid,
    input  exec_pkg::br_op_t                br_op,
    input  logic [exec_pkg::xlen-1:0]       br_a,
    input  logic [exec_pkg::xlen-1:0]       br_b,
    input  logic [exec_pkg::xlen-1:0]       br_pc,
    input  logic [exec_pkg::xlen-1:0]       br_imm,
    input  logic [exec_pkg::rob_idx_w-1:0]  br_rob_idx,
    input  logic [exec_pkg::preg_w-1:0]     br_pd,
    output logic                            br_ready,
    output logic                            res_valid,
    output logic [exec_pkg::rob_idx_w-1:0]  res_rob_idx,
    output logic [exec_pkg::preg_w-1:0]     res_pd,
    output logic [exec_pkg::xlen-1:0]       res_value,
    output logic                            res_redirect,
    output logic [exec_pkg::xlen-1:0]       res_target,
    input  logic                            res_take
);
    import exec_pkg::*;

    logic            taken;
    logic            is_jump;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] jalr_sum;
    logic [xlen-1:0] link;

    always_comb begin
        case (br_op)
            br_beq:  taken = br_a == br_b;
            br_bne:  taken = br_a != br_b;
            br_blt:  taken = $signed(br_a) < $signed(br_b);
            br_bge:  taken = $signed(br_a) >= $signed(br_b);
            br_bltu: taken = br_a < br_b;
            br_bgeu: taken = br_a >= br_b;
            // jumps always redirect
            default: taken = 1'b1;
        endcase
    end

    assign is_jump   = (br_op == br_jal) || (br_op == br_jalr);
    assign pc_target = br_pc + br_imm;
    assign jalr_sum  = br_a + br_imm;
    assign link      = br_pc + 32'd4;

    assign br_ready = !res_valid || res_take;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (br_valid && br_ready) begin
            res_valid <= 1'b1;
        end else if (res_take) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (br_valid && br_ready) begin
            res_rob_idx  <= br_rob_idx;
            res_pd       <= br_pd;
            res_value    <= is_jump ? link : '0;
            res_redirect <= taken;
            // jalr drops bit 0 of the sum
            res_target   <= (br_op == br_jalr) ? {jalr_sum[xlen-1:1], 1'b0} : pc_target;
        end
    end

endmodule

// ==== src/fu_mul.sv ====
`timescale 1ns/100ps

module fu_mul (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            mul_valid,
    input  exec_pkg::mul_op_t               mul_op,
    input  logic [exec_pkg::xlen-1:0]       mul_a,
    input  logic [exec_pkg::xlen-1:0]       mul_b,
    input  logic [exec_pkg::rob_idx_w-1:0]  mul_rob_idx,
    input  logic [exec_pkg::preg_w-1:0]     mul_pd,
    output logic                            mul_ready,
    output logic                            res_valid,
    output logic [exec_pkg::rob_idx_w-1:0]  res_rob_idx,
    output logic [exec_pkg::preg_w-1:0]     res_pd,
    output logic [exec_pkg::xlen-1:0]       res_value,
    input  logic                            res_take
);
    import exec_pkg::*;

    logic                   advance;
    logic                   a_signed;
    logic                   b_signed;
    logic [mul_stages-1:0]  vld;
    logic [rob_idx_w-1:0]   rob_q [mul_stages];
    logic [preg_w-1:0]      pd_q [mul_stages];
    // op is consumed by the last stage, so it is kept one stage short
    mul_op_t                op_q [mul_stages-1];

    logic signed [xlen:0]     a_ext;
    logic signed [xlen:0]     b_ext;
    logic signed [49:0]       pp_lo;
    logic signed [49:0]       pp_hi;
    logic signed [65:0]       pp_sum;
    logic [2*xlen-1:0]        prod;

    // whole pipe freezes while the last product waits for the cdb
    assign advance   = !(vld[mul_stages-1] && !res_take);
    assign mul_ready = advance;

    assign a_signed = (mul_op != mul_mulhu);
    assign b_signed = (mul_op == mul_mul) || (mul_op == mul_mulh);

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else if (advance) begin
            vld <= {vld[mul_stages-2:0], mul_valid};
        end
    end

    // tags and op shift beside the data
    always_ff @(posedge clk) begin
        if (advance) begin
            rob_q[0] <= mul_rob_idx;
            pd_q[0]  <= mul_pd;
            op_q[0]  <= mul_op;
            for (int i = 1; i < mul_stages; i++) begin
                rob_q[i] <= rob_q[i-1];
                pd_q[i]  <= pd_q[i-1];
            end
            for (int i = 1; i < mul_stages - 1; i++) begin
                op_q[i] <= op_q[i-1];
            end
        end
    end

    // 33x17 partial products, b split at bit 16
    assign pp_sum = {{16{pp_lo[49]}}, pp_lo} + ({{16{pp_hi[49]}}, pp_hi} <<< 16);

    always_ff @(posedge clk) begin
        if (advance) begin
            a_ext     <= $signed({a_signed & mul_a[xlen-1], mul_a});
            b_ext     <= $signed({b_signed & mul_b[xlen-1], mul_b});
            pp_lo     <= 50'(a_ext) * 50'($signed({1'b0, b_ext[15:0]}));
            pp_hi     <= 50'(a_ext) * 50'($signed(b_ext[xlen:16]));
            prod      <= pp_sum[2*xlen-1:0];
            res_value <= (op_q[mul_stages-2] == mul_mul) ? prod[xlen-1:0] : prod[2*xlen-1:xlen];
        end
    end

    assign res_valid   = vld[mul_stages-1];
    assign res_rob_idx = rob_q[mul_stages-1];
    assign res_pd      = pd_q[mul_stages-1];

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (res_valid && !res_take) |=>
            (res_valid && $stable(res_rob_idx) && $stable(res_pd) && $stable(res_value)));

endmodule

// ==== src/cdb_arbiter.sv ====
`timescale 1ns/100ps

module cdb_arbiter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            alu_res_valid,
    input  logic [exec_pkg::rob_idx_w-1:0]  alu_res_rob_idx,
    input  logic [exec_pkg::preg_w-1:0]     alu_res_pd,
    input  logic [exec_pkg::xlen-1:0]       alu_res_value,
    output logic                            alu_res_take,
    input  logic                            br_res_valid,
    input  logic [exec_pkg::rob_idx_w-1:0]  br_res_rob_idx,
    input  logic [exec_pkg::preg_w-1:0]     br_res_pd,
    input  logic [exec_pkg::xlen-1:0]       br_res_value,
    input  logic                            br_res_redirect,
    input  logic [exec_pkg::xlen-1:0]       br_res_target,
    output logic                            br_res_take,
    input  logic                            mul_res_valid,
    input  logic [exec_pkg::rob_idx_w-1:0]  mul_res_rob_idx,
    input  logic [exec_pkg::preg_w-1:0]     mul_res_pd,
    input  logic [exec_pkg::xlen-1:0]       mul_res_value,
    output logic                            mul_res_take,
    output logic                            cdb_valid,
    output logic [exec_pkg::rob_idx_w-1:0]  cdb_rob_idx,
    output logic [exec_pkg::preg_w-1:0]     cdb_pd,
    output logic [exec_pkg::xlen-1:0]       cdb_value,
    output logic                            cdb_redirect,
    output logic [exec_pkg::xlen-1:0]       cdb_target,
    input  logic                            cdb_ready
);
    import exec_pkg::*;

    unit_sel_t ptr;
    unit_sel_t grant_sel;
    logic      grant_any;
    logic      load;

    function automatic unit_sel_t next_unit(input unit_sel_t u);
        case (u)
            sel_alu: next_unit = sel_br;
            sel_br:  next_unit = sel_mul;
            default: next_unit = sel_alu;
        endcase
    endfunction

    // first valid slot at or after the pointer
    always_comb begin
        unit_sel_t cand;
        logic      cand_vld;
        grant_sel = ptr;
        grant_any = 1'b0;
        cand      = ptr;
        for (int i = 0; i < 3; i++) begin
            case (cand)
                sel_alu: cand_vld = alu_res_valid;
                sel_br:  cand_vld = br_res_valid;
                sel_mul: cand_vld = mul_res_valid;
                default: cand_vld = 1'b0;
            endcase
            if (cand_vld && !grant_any) begin
                grant_sel = cand;
                grant_any = 1'b1;
            end
            cand = next_unit(cand);
        end
    end

    assign load         = (!cdb_valid || cdb_ready) && grant_any;
    assign alu_res_take = load && (grant_sel == sel_alu);
    assign br_res_take  = load && (grant_sel == sel_br);
    assign mul_res_take = load && (grant_sel == sel_mul);

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
            ptr       <= sel_alu;
        end else if (load) begin
            cdb_valid <= 1'b1;
            ptr       <= next_unit(grant_sel);
        end else if (cdb_ready) begin
            cdb_valid <= 1'b0;
        end
    end

    // only branch results carry a redirect
    always_ff @(posedge clk) begin
        if (load) begin
            case (grant_sel)
                sel_br: begin
                    cdb_rob_idx  <= br_res_rob_idx;
                    cdb_pd       <= br_res_pd;
                    cdb_value    <= br_res_value;
                    cdb_redirect <= br_res_redirect;
                    cdb_target   <= br_res_target;
                end
                sel_mul: begin
                    cdb_rob_idx  <= mul_res_rob_idx;
                    cdb_pd       <= mul_res_pd;
                    cdb_value    <= mul_res_value;
                    cdb_redirect <= 1'b0;
                    cdb_target   <= '0;
                end
                default: begin
                    cdb_rob_idx  <= alu_res_rob_idx;
                    cdb_pd       <= alu_res_pd;
                    cdb_value    <= alu_res_value;
                    cdb_redirect <= 1'b0;
                    cdb_target   <= '0;
                end
            endcase
        end
    end

    a_take_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({alu_res_take, br_res_take, mul_res_take}));

    a_take_valid: assert property (@(posedge clk) disable iff (rst)
        load |-> ((grant_sel == sel_alu && alu_res_valid) ||
                  (grant_sel == sel_br && br_res_valid) ||
                  (grant_sel == sel_mul && mul_res_valid)));

    a_cdb_stable: assert property (@(posedge clk) disable iff (rst)
        (cdb_valid && !cdb_ready) |=>
            (cdb_valid && $stable(cdb_rob_idx) && $stable(cdb_pd) && $stable(cdb_value)
             && $stable(cdb_redirect) && $stable(cdb_target)));

endmodule

// ==== src/execute.sv ====
`timescale 1ns/100ps

module execute (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            alu_valid,
    output logic                            alu_ready,
    input  exec_pkg::alu_op_t               alu_op,
    input  logic [exec_pkg::xlen-1:0]       alu_a,
    input  logic [exec_pkg::xlen-1:0]       alu_b,
    input  logic [exec_pkg::rob_idx_w-1:0]  alu_rob_idx,
    input  logic [exec_pkg::preg_w-1:0]     alu_pd,
    input  logic                            br_valid,
    output logic                            br_ready,
    input  exec_pkg::br_op_t                br_op,
    input  logic [exec_pkg::xlen-1:0]       br_a,
    input  logic [exec_pkg::xlen-1:0]       br_b,
    input  logic [exec_pkg::xlen-1:0]       br_pc,
    input  logic [exec_pkg::xlen-1:0]       br_imm,
    input  logic [exec_pkg::rob_idx_w-1:0]  br_rob_idx,
    input  logic [exec_pkg::preg_w-1:0]     br_pd,
    input  logic                            mul_valid,
    output logic                            mul_ready,
    input  exec_pkg::mul_op_t               mul_op,
    input  logic [exec_pkg::xlen-1:0]       mul_a,
    input  logic [exec_pkg::xlen-1:0]       mul_b,
    input  logic [exec_pkg::rob_idx_w-1:0]  mul_rob_idx,
    input  logic [exec_pkg::preg_w-1:0]     mul_pd,
    output logic                            cdb_valid,
    output logic [exec_pkg::rob_idx_w-1:0]  cdb_rob_idx,
    output logic [exec_pkg::preg_w-1:0]     cdb_pd,
    output logic [exec_pkg::xlen-1:0]       cdb_value,
    output logic                            cdb_redirect,
    output logic [exec_pkg::xlen-1:0]       cdb_target,
    input  logic                            cdb_ready
);
    import exec_pkg::*;

    // result slots between the units and the arbiter
    logic                 alu_res_valid, br_res_valid, mul_res_valid;
    logic                 alu_res_take, br_res_take, mul_res_take;
    logic [rob_idx_w-1:0] alu_res_rob_idx, br_res_rob_idx, mul_res_rob_idx;
    logic [preg_w-1:0]    alu_res_pd, br_res_pd, mul_res_pd;
    logic [xlen-1:0]      alu_res_value, br_res_value, mul_res_value;
    logic                 br_res_redirect;
    logic [xlen-1:0]      br_res_target;

    fu_alu u_alu (
        .clk(clk), .rst(rst),
        .alu_valid(alu_valid), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_rob_idx(alu_rob_idx), .alu_pd(alu_pd), .alu_ready(alu_ready),
        .res_valid(alu_res_valid), .res_rob_idx(alu_res_rob_idx), .res_pd(alu_res_pd),
        .res_value(alu_res_value), .res_take(alu_res_take)
    );

    fu_branch u_branch (
        .clk(clk), .rst(rst),
        .br_valid(br_valid), .br_op(br_op), .br_a(br_a), .br_b(br_b),
        .br_pc(br_pc), .br_imm(br_imm),
        .br_rob_idx(br_rob_idx), .br_pd(br_pd), .br_ready(br_ready),
        .res_valid(br_res_valid), .res_rob_idx(br_res_rob_idx), .res_pd(br_res_pd),
        .res_value(br_res_value), .res_redirect(br_res_redirect),
        .res_target(br_res_target), .res_take(br_res_take)
    );

    fu_mul u_mul (
        .clk(clk), .rst(rst),
        .mul_valid(mul_valid), .mul_op(mul_op), .mul_a(mul_a), .mul_b(mul_b),
        .mul_rob_idx(mul_rob_idx), .mul_pd(mul_pd), .mul_ready(mul_ready),
        .res_valid(mul_res_valid), .res_rob_idx(mul_res_rob_idx), .res_pd(mul_res_pd),
        .res_value(mul_res_value), .res_take(mul_res_take)
    );

    cdb_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .alu_res_valid(alu_res_valid), .alu_res_rob_idx(alu_res_rob_idx),
        .alu_res_pd(alu_res_pd), .alu_res_value(alu_res_value), .alu_res_take(alu_res_take),
        .br_res_valid(br_res_valid), .br_res_rob_idx(br_res_rob_idx),
        .br_res_pd(br_res_pd), .br_res_value(br_res_value),
        .br_res_redirect(br_res_redirect), .br_res_target(br_res_target),
        .br_res_take(br_res_take),
        .mul_res_valid(mul_res_valid), .mul_res_rob_idx(mul_res_rob_idx),
        .mul_res_pd(mul_res_pd), .mul_res_value(mul_res_value), .mul_res_take(mul_res_take),
        .cdb_valid(cdb_valid), .cdb_rob_idx(cdb_rob_idx), .cdb_pd(cdb_pd),
        .cdb_value(cdb_value), .cdb_redirect(cdb_redirect), .cdb_target(cdb_target),
        .cdb_ready(cdb_ready)
    );

endmodule

// ==== tb/execute_tb.sv ====
`timescale 1ns/100ps

module execute_tb;
    import exec_pkg::*;

    localparam int max_lines = 32;
    localparam int ncols = 11;
    localparam int timeout_cycles = 200;
    localparam logic [31:0] lfsr_seed = 32'h083c_b1e1;

    logic                 clk;
    logic                 rst;
    logic                 alu_valid, br_valid, mul_valid;
    logic                 alu_ready, br_ready, mul_ready;
    alu_op_t              alu_op;
    br_op_t               br_op;
    mul_op_t              mul_op;
    logic [xlen-1:0]      alu_a, alu_b, br_a, br_b, br_pc, br_imm, mul_a, mul_b;
    logic [rob_idx_w-1:0] alu_rob_idx, br_rob_idx, mul_rob_idx;
    logic [preg_w-1:0]    alu_pd, br_pd, mul_pd;
    logic                 cdb_valid, cdb_ready, cdb_redirect;
    logic [rob_idx_w-1:0] cdb_rob_idx;
    logic [preg_w-1:0]    cdb_pd;
    logic [xlen-1:0]      cdb_value, cdb_target;

    // stimulus columns in order unit op a b pc imm rob_idx pd value redirect target
    logic [31:0] stim [max_lines*ncols];

    int          nlines;
    int          consumed;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          unstable_cnt;
    int          unknown_cnt;
    logic        timed_out;
    logic        throttle;
    logic [31:0] lfsr;
    logic        first_bit;
    logic        next_ready;
    string       cdb_names [5];

    // scoreboard with one entry per rob_idx
    int          seen_cnt [64];
    logic [31:0] seen [64][5];
    logic        known [64];

    // cdb word that was waiting at the last edge
    logic        held;
    logic [31:0] held_fields [5];

    execute dut0 (
        .clk(clk), .rst(rst),
        .alu_valid(alu_valid), .alu_ready(alu_ready), .alu_op(alu_op),
        .alu_a(alu_a), .alu_b(alu_b), .alu_rob_idx(alu_rob_idx), .alu_pd(alu_pd),
        .br_valid(br_valid), .br_ready(br_ready), .br_op(br_op),
        .br_a(br_a), .br_b(br_b), .br_pc(br_pc), .br_imm(br_imm),
        .br_rob_idx(br_rob_idx), .br_pd(br_pd),
        .mul_valid(mul_valid), .mul_ready(mul_ready), .mul_op(mul_op),
        .mul_a(mul_a), .mul_b(mul_b), .mul_rob_idx(mul_rob_idx), .mul_pd(mul_pd),
        .cdb_valid(cdb_valid), .cdb_rob_idx(cdb_rob_idx), .cdb_pd(cdb_pd),
        .cdb_value(cdb_value), .cdb_redirect(cdb_redirect), .cdb_target(cdb_target),
        .cdb_ready(cdb_ready)
    );

    // 4 ns period
    always #2 clk = ~clk;

    function automatic logic [31:0] field(input int line, input int col);
        field = stim[line*ncols + col];
    endfunction

    function automatic logic [5:0] rob_of(input int line);
        rob_of = stim[line*ncols + 6][5:0];
    endfunction

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] cdb_field(input int k);
        case (k)
            0:       cdb_field = 32'(cdb_rob_idx);
            1:       cdb_field = 32'(cdb_pd);
            2:       cdb_field = cdb_value;
            3:       cdb_field = 32'(cdb_redirect);
            default: cdb_field = cdb_target;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp,
                           input logic [31:0] act, inout int fails);
        if (exp !== act) begin
            $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
            fails++;
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int fails);
        tests_run++;
        if (fails != 0) begin
            tests_failed++;
        end
        $display("%s: %s, %0d errors", name, (fails == 0) ? "ok" : "bad", fails);
    endtask

    // called 1 ns after an edge and returns 1 ns after the accepting edge
    task automatic issue_line(input int i);
        int          unit;
        int          waited;
        logic        rdy;
        logic [31:0] op;
        logic [31:0] pd;
        unit = field(i, 0);
        op = field(i, 1);
        pd = field(i, 7);
        case (unit)
            0: begin
                alu_op = alu_op_t'(op[3:0]);
                alu_a = field(i, 2);
                alu_b = field(i, 3);
                alu_rob_idx = rob_of(i);
                alu_pd = pd[5:0];
                alu_valid = 1'b1;
            end
            1: begin
                br_op = br_op_t'(op[2:0]);
                br_a = field(i, 2);
                br_b = field(i, 3);
                br_pc = field(i, 4);
                br_imm = field(i, 5);
                br_rob_idx = rob_of(i);
                br_pd = pd[5:0];
                br_valid = 1'b1;
            end
            default: begin
                mul_op = mul_op_t'(op[1:0]);
                mul_a = field(i, 2);
                mul_b = field(i, 3);
                mul_rob_idx = rob_of(i);
                mul_pd = pd[5:0];
                mul_valid = 1'b1;
            end
        endcase
        waited = 0;
        rdy = 1'b0;
        while (!rdy && !timed_out) begin
            @(posedge clk);
            case (unit)
                0:       rdy = alu_ready;
                1:       rdy = br_ready;
                default: rdy = mul_ready;
            endcase
            waited++;
            if (!rdy && waited >= timeout_cycles) begin
                $display("timeout: line %0d of the stimulus was never accepted", i);
                timed_out = 1'b1;
                errors++;
            end
        end
        #1;
        alu_valid = 1'b0;
        br_valid = 1'b0;
        mul_valid = 1'b0;
    endtask

    // edges from the issue edge to the edge that sees cdb_valid
    task automatic measure_latency(input int i, input int expected, input string name,
                                   inout int fails);
        int   lat;
        logic saw;
        issue_line(i);
        lat = 0;
        saw = 1'b0;
        while (!saw && !timed_out) begin
            @(posedge clk);
            lat++;
            saw = cdb_valid;
            if (!saw && lat >= timeout_cycles) begin
                $display("timeout: the %s result never reached the cdb", name);
                timed_out = 1'b1;
                errors++;
            end
        end
        #1;
        compare($sformatf("%s issue to cdb_valid cycles", name), expected, lat, fails);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (consumed < nlines && !timed_out) begin
            @(negedge clk);
            waited++;
            if (consumed < nlines && waited >= timeout_cycles) begin
                $display("timeout: only %0d of %0d results left the cdb", consumed, nlines);
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic check_unit(input int unit, input string name);
        int         fails;
        logic [5:0] r;
        fails = 0;
        for (int i = 0; i < nlines; i++) begin
            if (field(i, 0) == unit) begin
                r = rob_of(i);
                if (seen_cnt[r] == 0) begin
                    $display("rob_idx %0d from line %0d never reached the cdb", r, i);
                    fails++;
                    errors++;
                end else begin
                    for (int k = 1; k < 5; k++) begin
                        compare($sformatf("%s for rob_idx %0d", cdb_names[k], r),
                                field(i, 6 + k), seen[r][k], fails);
                    end
                end
            end
        end
        report_test(name, fails);
    endtask

    // cdb_ready low about one cycle in four while throttled
    always @(posedge clk) begin
        next_ready = 1'b1;
        if (throttle) begin
            lfsr = lfsr_step(lfsr);
            first_bit = lfsr[0];
            lfsr = lfsr_step(lfsr);
            next_ready = !(first_bit && lfsr[0]);
        end
        #1;
        cdb_ready = next_ready;
    end

    // cdb monitor
    always @(posedge clk) begin
        if (rst) begin
            held = 1'b0;
        end else begin
            if (held) begin
                compare("cdb_valid while held", 32'd1, 32'(cdb_valid), unstable_cnt);
                for (int k = 0; k < 5; k++) begin
                    compare(cdb_names[k], held_fields[k], cdb_field(k), unstable_cnt);
                end
            end
            if (cdb_valid && cdb_ready) begin
                if (!known[cdb_rob_idx]) begin
                    $display("at %0t the cdb carried rob_idx %0d, which was never issued",
                             $time, cdb_rob_idx);
                    unknown_cnt++;
                    errors++;
                end
                seen_cnt[cdb_rob_idx]++;
                for (int k = 0; k < 5; k++) begin
                    seen[cdb_rob_idx][k] = cdb_field(k);
                end
                consumed++;
            end
            held = cdb_valid && !cdb_ready;
            for (int k = 0; k < 5; k++) begin
                held_fields[k] = cdb_field(k);
            end
        end
    end

    initial begin
        int fails;
        clk = 1'b0;
        rst = 1'b1;
        alu_valid = 1'b0;
        br_valid = 1'b0;
        mul_valid = 1'b0;
        alu_op = alu_add;
        br_op = br_beq;
        mul_op = mul_mul;
        alu_a = '0;
        alu_b = '0;
        br_a = '0;
        br_b = '0;
        br_pc = '0;
        br_imm = '0;
        mul_a = '0;
        mul_b = '0;
        alu_rob_idx = '0;
        br_rob_idx = '0;
        mul_rob_idx = '0;
        alu_pd = '0;
        br_pd = '0;
        mul_pd = '0;
        cdb_ready = 1'b1;
        throttle = 1'b0;
        lfsr = lfsr_seed;
        held = 1'b0;
        timed_out = 1'b0;
        nlines = 0;
        consumed = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        unstable_cnt = 0;
        unknown_cnt = 0;
        cdb_names = '{"cdb_rob_idx", "cdb_pd", "cdb_value", "cdb_redirect", "cdb_target"};
        seen_cnt = '{default: 0};
        known = '{default: 1'b0};
        stim = '{default: 32'hffff_ffff};
        $readmemh("tb/exec_stim.txt", stim);
        // an all ones unit column marks the end of the file
        while (nlines < max_lines && field(nlines, 0) != 32'hffff_ffff) begin
            known[rob_of(nlines)] = 1'b1;
            nlines++;
        end

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        fails = 0;
        compare("cdb_valid", 32'd0, 32'(cdb_valid), fails);
        compare("alu_ready", 32'd1, 32'(alu_ready), fails);
        compare("br_ready", 32'd1, 32'(br_ready), fails);
        compare("mul_ready", 32'd1, 32'(mul_ready), fails);
        report_test("reset state", fails);

        // phase 1 runs lines 0 and 1 alone with cdb_ready high
        fails = 0;
        measure_latency(0, 2, "alu", fails);
        measure_latency(1, 5, "multiplier", fails);
        report_test("unloaded latency", fails);

        // phase 2 runs the rest against a throttled cdb
        throttle = 1'b1;
        for (int i = 2; i < nlines; i++) begin
            issue_line(i);
        end
        throttle = 1'b0;
        wait_drain();
        // idle a little longer so a duplicate would still show up
        repeat (8) @(negedge clk);

        check_unit(0, "alu results");
        check_unit(2, "multiplier results");
        check_unit(1, "branch results");

        fails = unstable_cnt + unknown_cnt;
        for (int i = 0; i < nlines; i++) begin
            if (seen_cnt[rob_of(i)] != 1) begin
                $display("rob_idx %0d appeared %0d times on the cdb instead of once",
                         rob_of(i), seen_cnt[rob_of(i)]);
                fails++;
                errors++;
            end
        end
        report_test("back-pressure without loss", fails);

        $display("%0d tests run, %0d bad, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb/exec_stim.txt ====
// unit op a b pc imm rob_idx pd value redirect target
// unit 0 alu, 1 branch, 2 multiplier; lines 0 and 1 run alone with the cdb unloaded
0 0 00000005 00000007 00000000 00000000 01 21 0000000c 0 00000000
2 0 00000003 fffffffe 00000000 00000000 02 22 fffffffa 0 00000000
2 1 fffffffe 00000003 00000000 00000000 03 23 ffffffff 0 00000000
2 2 ffffffff ffffffff 00000000 00000000 04 24 ffffffff 0 00000000
2 3 ffffffff ffffffff 00000000 00000000 05 25 fffffffe 0 00000000
2 1 80000000 80000000 00000000 00000000 06 26 40000000 0 00000000
2 0 12345678 00000010 00000000 00000000 07 27 23456780 0 00000000
2 2 00000002 80000000 00000000 00000000 08 28 00000001 0 00000000
0 1 00000010 00000020 00000000 00000000 09 29 fffffff0 0 00000000
1 0 00000005 00000005 00001000 00000010 0a 2a 00000000 1 00001010
0 2 f0f0ff00 0ff00ff0 00000000 00000000 0b 2b 00f00f00 0 00000000
1 1 00000005 00000005 00001004 fffffff0 0c 2c 00000000 0 00000ff4
0 3 12340000 00005678 00000000 00000000 0d 2d 12345678 0 00000000
1 2 fffffff0 00000001 00002000 00000100 0e 2e 00000000 1 00002100
0 4 ffff0000 0f0f0f0f 00000000 00000000 0f 2f f0f00f0f 0 00000000
1 3 fffffff0 00000001 00002004 00000008 10 30 00000000 0 0000200c
0 5 00000001 00000024 00000000 00000000 11 31 00000010 0 00000000
1 4 fffffff0 00000001 00003000 00000020 12 32 00000000 0 00003020
0 6 80000000 00000004 00000000 00000000 13 33 08000000 0 00000000
1 5 fffffff0 00000001 00003004 00000040 14 34 00000000 1 00003044
0 7 80000000 00000004 00000000 00000000 15 35 f8000000 0 00000000
1 6 00000000 00000000 00004000 00000800 16 36 00004004 1 00004800
0 8 ffffffff 00000001 00000000 00000000 17 37 00000001 0 00000000
1 7 00005003 00000000 00004010 00000004 18 38 00004014 1 00005006
0 9 ffffffff 00000001 00000000 00000000 19 39 00000000 0 00000000

// ==== flist.f ====
src/exec_pkg.sv
src/fu_alu.sv
src/fu_branch.sv
src/fu_mul.sv
src/cdb_arbiter.sv
src/execute.sv
tb/execute_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := execute_tb
FLIST      := flist.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
